//--- rob_tests.txt
// columns: test cmd a b c d e (hex); cmd 1 disp a=opcode b=funct3 c=rd d=pc e=pred_taken
// cmd 2 wb a=src(0 alu 1 lsb) b=tag c=value d=addr; 4 drain a=done delay; 5 counts a=credits b=regs
1 7 0 0 0 0 0
1 5 0 0 0 0 0
1 a 0 0 0 0 0
2 1 33 0 1 100 0
2 1 3 2 2 104 0
2 1 13 0 3 108 0
2 1 3 2 4 10c 0
2 2 0 2 33333333 0 0
2 2 0 0 11111111 0 0
2 2 1 1 22222222 0 0
2 2 1 3 44444444 0 0
2 3 0 0 0 0 0
2 4 0 0 0 0 0
2 5 4 4 0 0 0
2 a 0 0 0 0 0
3 1 23 0 0 110 0
3 1 33 0 5 114 0
3 1 23 1 0 118 0
3 1 23 2 0 11c 0
3 2 1 4 000000ab 2000 0
3 2 0 5 55555555 0 0
3 2 1 6 0000beef 2002 0
3 2 1 7 deadbeef 2004 0
3 3 0 0 0 0 0
3 4 5 0 0 0 0
3 5 4 1 0 0 0
3 a 0 0 0 0 0
4 1 63 0 0 200 0
4 1 33 0 6 204 0
4 2 0 8 0 260 0
4 2 0 9 66666666 0 0
4 3 0 0 0 0 0
4 4 0 0 0 0 0
4 1 63 1 0 208 0
4 1 33 0 7 20c 0
4 2 0 a 1 400 0
4 2 0 b 77777777 0 0
4 3 0 0 0 0 0
4 4 0 0 0 0 0
4 1 63 0 0 300 1
4 1 33 0 8 304 0
4 2 0 0 0 380 0
4 2 0 1 88888888 0 0
4 3 0 0 0 0 0
4 4 0 0 0 0 0
4 5 4 1 0 0 0
4 a 0 0 0 0 0
5 8 10 0 0 500 0
5 6 0 0 0 0 0
5 9 0 0 a0000000 0 0
5 3 0 0 0 0 0
5 4 0 0 0 0 0
5 6 10 0 0 0 0
5 1 33 0 9 600 0
5 2 0 0 99999999 0 0
5 3 0 0 0 0 0
5 4 0 0 0 0 0
5 5 11 11 0 0 0
5 a 0 0 0 0 0
0 0 0 0 0 0 0

//--- rob_top.f
rob_pkg.sv
rob_dispatch.sv
rob_entry_table.sv
rob_commit.sv
rob_top.sv
rob_assert.sv
tb_rob_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rob_top -f rob_top.f -o sim_rob

out=$(./obj_dir/sim_rob)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi

//--- tb_rob_top.sv
`timescale 1ns/1ps

module tb_rob_top import rob_pkg::*; ();

    // seven hex columns per record
    localparam int rec_w       = 7;
    localparam int max_rec     = 128;
    localparam int drain_limit = 64;

    // command codes of the test file
    localparam logic [31:0] c_stop     = 32'h0;
    localparam logic [31:0] c_disp     = 32'h1;
    localparam logic [31:0] c_wb       = 32'h2;
    localparam logic [31:0] c_fire     = 32'h3;
    localparam logic [31:0] c_drain    = 32'h4;
    localparam logic [31:0] c_counts   = 32'h5;
    localparam logic [31:0] c_credits  = 32'h6;
    localparam logic [31:0] c_idle     = 32'h7;
    localparam logic [31:0] c_burst    = 32'h8;
    localparam logic [31:0] c_wb_all   = 32'h9;
    localparam logic [31:0] c_end_test = 32'ha;

    // one outstanding entry in dispatch order
    typedef struct packed {
        op_kind_t    kind;
        store_size_t size;
        reg_idx_t    rd;
        rob_tag_t    tag;
        addr_t       pc;
        logic        pt;
    } expect_t;

    // src 0 is the alu port, 1 the lsb port
    typedef struct packed {
        logic     src;
        rob_tag_t tag;
        word_t    value;
        addr_t    addr;
    } wb_item_t;

    logic          alu_broadcast;
    logic          rst;
    dispatch_req_t dispatch;
    wb_t           alu_wb;
    wb_t           lsb_wb;
    logic          store_done;
    reg_commit_t   reg_commit;
    store_req_t    store_req;
    logic          credit_return;
    logic          redirect;
    addr_t         redirect_pc;

    logic [31:0] tests_mem [rec_w*max_rec];
    int          n_rec;
    logic        loaded;
    int          seed;

    // reference model
    expect_t   expq [$];
    wb_item_t  wbq [$];
    word_t     model_value [rob_depth];
    addr_t     model_addr [rob_depth];
    rob_tag_t  tail_model;
    int        disp_cnt;
    int        ret_cnt;

    // bookkeeping
    int   cur_test;
    int   test_credits;
    int   test_regs;
    int   errors;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    int   store_wait;
    int   store_delay;
    logic done_sent;
    logic want_done;
    logic store_seen;
    logic idle_req;

    rob_top DUT (
        .alu_broadcast (alu_broadcast),
        .rst           (rst),
        .dispatch      (dispatch),
        .alu_wb        (alu_wb),
        .lsb_wb        (lsb_wb),
        .store_done    (store_done),
        .reg_commit    (reg_commit),
        .store_req     (store_req),
        .credit_return (credit_return),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

    // 40 ns period
    initial alu_broadcast = 1'b0;
    always #20 alu_broadcast = ~alu_broadcast;

    // rv32 major opcode to entry kind
    function automatic op_kind_t kind_of(input logic [6:0] opcode);
        case (opcode)
            7'b0000011: return kind_load;
            7'b0100011: return kind_store;
            7'b1100011: return kind_branch;
            default:    return kind_alu;
        endcase
    endfunction

    // sb, sh, sw
    function automatic store_size_t size_of(input logic [2:0] funct3);
        case (funct3[1:0])
            2'b00:   return size_byte;
            2'b01:   return size_half;
            default: return size_word;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("error in test %0d: %s", cur_test, what);
        errors++;
        test_errors++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h (test %0d)", name, got, exp, cur_test);
            errors++;
            test_errors++;
        end
    endtask

    // sample outputs mid cycle, where they are stable
    task automatic check_outputs();
        expect_t e;
        logic    taken;
        addr_t   exp_pc;
        want_done  = 1'b0;
        store_seen = store_req.valid;
        // store_done after a programmable wait
        if (store_req.valid) begin
            if (!done_sent) begin
                if (store_wait >= store_delay) begin
                    want_done = 1'b1;
                    done_sent = 1'b1;
                end else begin
                    store_wait++;
                end
            end
        end else begin
            store_wait = 0;
            done_sent  = 1'b0;
        end
        if (idle_req) begin
            idle_req = 1'b0;
            if (reg_commit.valid) report_failure("reg_commit.valid high after reset");
            if (store_req.valid) report_failure("store_req.valid high after reset");
            if (credit_return) report_failure("credit_return high after reset");
            if (redirect) report_failure("redirect high after reset");
        end
        if (reg_commit.valid && store_req.valid) begin
            report_failure("register commit while a store waits for store_done");
        end
        if (reg_commit.valid) test_regs++;
        if (credit_return) begin
            ret_cnt++;
            test_credits++;
            if (expq.size() == 0) begin
                report_failure("credit_return pulsed with no entry outstanding");
            end else begin
                e = expq.pop_front();
                if (redirect && e.kind != kind_branch) begin
                    report_failure("redirect on a commit that is not a branch");
                end
                case (e.kind)
                    kind_store: begin
                        if (!store_req.valid) begin
                            report_failure("store retired without store_req");
                        end else begin
                            compare_value("store_req.size", 32'(store_req.size), 32'(e.size));
                            compare_value("store_req.addr", store_req.addr, model_addr[e.tag]);
                            compare_value("store_req.data", store_req.data, model_value[e.tag]);
                        end
                    end
                    kind_branch: begin
                        taken = model_value[e.tag][0];
                        if (reg_commit.valid) report_failure("branch wrote the register file");
                        if (taken != e.pt) begin
                            exp_pc = taken ? model_addr[e.tag] : e.pc + 32'd4;
                            if (!redirect) begin
                                report_failure("mispredicted branch gave no redirect");
                            end else begin
                                compare_value("redirect_pc", redirect_pc, exp_pc);
                            end
                            // younger entries are gone, credits back to full
                            expq.delete();
                            ret_cnt    = disp_cnt;
                            tail_model = '0;
                        end else if (redirect) begin
                            report_failure("redirect on a correctly predicted branch");
                        end
                    end
                    default: begin
                        if (!reg_commit.valid) begin
                            report_failure("register op retired without reg_commit");
                        end else begin
                            compare_value("reg_commit.rd", 32'(reg_commit.rd), 32'(e.rd));
                            compare_value("reg_commit.tag", 32'(reg_commit.tag), 32'(e.tag));
                            compare_value("reg_commit.value", reg_commit.value,
                                          model_value[e.tag]);
                        end
                    end
                endcase
            end
        end else if (reg_commit.valid || redirect) begin
            report_failure("commit output without credit_return");
        end
    endtask

    // one clock, checks at the falling edge, idle drive at the rising edge
    task automatic tick();
        @(negedge alu_broadcast);
        check_outputs();
        @(posedge alu_broadcast);
        dispatch.valid <= 1'b0;
        alu_wb.valid   <= 1'b0;
        lsb_wb.valid   <= 1'b0;
        store_done     <= want_done;
    endtask

    task automatic dispatch_op(input logic [6:0] opcode, input logic [2:0] funct3,
                               input reg_idx_t rd, input addr_t pc, input logic pt);
        expect_t e;
        int      waited;
        waited = 0;
        // hold back while no credit is left
        while (16 - (disp_cnt - ret_cnt) <= 0 && waited < drain_limit) begin
            tick();
            waited++;
        end
        if (16 - (disp_cnt - ret_cnt) <= 0) begin
            report_failure("no credit came back for a dispatch");
        end else begin
            tick();
            dispatch <= '{valid: 1'b1, opcode: opcode, funct3: funct3, rd: rd, pc: pc,
                          predicted_taken: pt};
            e.kind = kind_of(opcode);
            e.size = size_of(funct3);
            e.rd   = rd;
            e.tag  = tail_model;
            e.pc   = pc;
            e.pt   = pt;
            expq.push_back(e);
            tail_model = tail_model + rob_tag_t'(1);
            disp_cnt++;
        end
    endtask

    task automatic drive_wb(input wb_item_t w);
        if (w.src) begin
            lsb_wb <= '{valid: 1'b1, tag: w.tag, value: w.value, addr: w.addr};
        end else begin
            alu_wb <= '{valid: 1'b1, tag: w.tag, value: w.value, addr: w.addr};
        end
    endtask

    task automatic fire_writebacks();
        wb_item_t w;
        wb_item_t w2;
        int       j;
        // shuffle the queued writebacks
        for (int i = wbq.size() - 1; i > 0; i--) begin
            j      = $unsigned($random(seed)) % (i + 1);
            w      = wbq[i];
            wbq[i] = wbq[j];
            wbq[j] = w;
        end
        while (wbq.size() > 0) begin
            tick();
            w = wbq.pop_front();
            drive_wb(w);
            // both ports in one cycle when the next one uses the other port
            if (wbq.size() > 0 && wbq[0].src != w.src) begin
                w2 = wbq.pop_front();
                drive_wb(w2);
            end
        end
    endtask

    task automatic queue_wb(input logic src, input rob_tag_t tag, input word_t value,
                            input addr_t addr);
        wbq.push_back('{src: src, tag: tag, value: value, addr: addr});
        model_value[tag] = value;
        model_addr[tag]  = addr;
    endtask

    task automatic drain(input int delay);
        int waited;
        waited      = 0;
        store_delay = delay;
        while ((expq.size() > 0 || store_seen) && waited < drain_limit) begin
            tick();
            waited++;
        end
        if (expq.size() > 0 || store_seen) begin
            report_failure("commit did not drain in time");
            expq.delete();
        end
        // let a flush settle
        tick();
        tick();
    endtask

    // watchdog scaled by the number of records
    initial begin
        wait (loaded);
        repeat (n_rec * 64 + 200) @(posedge alu_broadcast);
        $display("watchdog expired, simulation hung");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int          base;
        logic [31:0] cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        seed         = 32'h1b54eb36;
        rst          = 1'b1;
        dispatch     = '0;
        alu_wb       = '0;
        lsb_wb       = '0;
        store_done   = 1'b0;
        loaded       = 1'b0;
        tail_model   = '0;
        disp_cnt     = 0;
        ret_cnt      = 0;
        cur_test     = 0;
        test_credits = 0;
        test_regs    = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        store_wait   = 0;
        store_delay  = 0;
        done_sent    = 1'b0;
        want_done    = 1'b0;
        store_seen   = 1'b0;
        idle_req     = 1'b0;
        for (int i = 0; i < rec_w * max_rec; i++) tests_mem[i] = '0;
        $readmemh("rob_tests.txt", tests_mem);
        n_rec = 0;
        while (n_rec < max_rec && tests_mem[n_rec * rec_w + 1] != c_stop) n_rec++;
        loaded = 1'b1;

        repeat (10) @(posedge alu_broadcast);
        rst <= 1'b0;

        for (int r = 0; r < n_rec; r++) begin
            base     = r * rec_w;
            cur_test = int'(tests_mem[base]);
            cmd      = tests_mem[base + 1];
            a        = tests_mem[base + 2];
            b        = tests_mem[base + 3];
            c        = tests_mem[base + 4];
            d        = tests_mem[base + 5];
            e        = tests_mem[base + 6];
            case (cmd)
                c_disp:   dispatch_op(a[6:0], b[2:0], c[4:0], d, e[0]);
                c_wb:     queue_wb(a[0], b[3:0], c, d);
                c_fire:   fire_writebacks();
                c_drain:  drain(int'(a));
                c_counts: begin
                    compare_value("credit_return count", 32'(test_credits), a);
                    compare_value("reg_commit count", 32'(test_regs), b);
                end
                c_credits: compare_value("credits", 32'(16 - (disp_cnt - ret_cnt)), a);
                c_idle: begin
                    idle_req = 1'b1;
                    tick();
                end
                c_burst: begin
                    for (int k = 0; k < int'(a); k++) begin
                        dispatch_op(7'b0110011, 3'd0, reg_idx_t'(k + 1), d + 32'(k * 4), 1'b0);
                    end
                end
                c_wb_all: begin
                    foreach (expq[k]) begin
                        queue_wb(expq[k].tag[0], expq[k].tag, c + 32'(expq[k].tag), '0);
                    end
                end
                c_end_test: begin
                    tests_run++;
                    if (test_errors != 0) tests_failed++;
                    $display("test %0d %s: %0d credits, %0d reg commits", cur_test,
                             (test_errors == 0) ? "passed" : "failed", test_credits, test_regs);
                    test_errors  = 0;
                    test_credits = 0;
                    test_regs    = 0;
                end
                default: report_failure("unknown command in test file");
            endcase
        end
        tick();
        tick();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- rob_assert.sv
`timescale 1ns/1ps

module rob_assert import rob_pkg::*; (
    input logic        alu_broadcast,
    input logic        rst,
    input rob_entry_t  head_entry,
    input logic        store_done,
    input reg_commit_t reg_commit,
    input store_req_t  store_req,
    input logic        credit_return,
    input logic        redirect
);

    // store request frozen until the lsb reports done
    store_hold: assert property (@(posedge alu_broadcast) disable iff (rst)
        store_req.valid && !store_done |=> $stable(store_req))
        else $error("store_req changed while waiting for store_done");

    // no other commit output while a store is issued or waits for done
    store_alone: assert property (@(posedge alu_broadcast) disable iff (rst)
        store_req.valid |-> !reg_commit.valid && !redirect)
        else $error("reg_commit or redirect while store_req is valid");

    // credit comes from an entry that really left the head
    credit_busy: assert property (@(posedge alu_broadcast) disable iff (rst)
        credit_return |-> $past(head_entry.busy))
        else $error("credit_return while the head was not busy");

endmodule

bind rob_commit rob_assert u_rob_assert (
    .alu_broadcast (alu_broadcast),
    .rst           (rst),
    .head_entry    (head_entry),
    .store_done    (store_done),
    .reg_commit    (reg_commit),
    .store_req     (store_req),
    .credit_return (credit_return),
    .redirect      (redirect)
);

//--- rob_top.sv
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
    input  logic          alu_broadcast,
    input  logic          rst,
    input  dispatch_req_t dispatch,
    input  wb_t           alu_wb,
    input  wb_t           lsb_wb,
    input  logic          store_done,
    output reg_commit_t   reg_commit,
    output store_req_t    store_req,
    output logic          credit_return,
    output logic          redirect,
    output addr_t         redirect_pc
);

    // dispatch to table
    logic       alloc_we;
    rob_tag_t   alloc_tag;
    rob_entry_t alloc_entry;

    // table and commit loop
    rob_entry_t head_entry;
    rob_tag_t   head_tag;
    logic       retire;
    logic       flush;

    // input side, tail pointer and decode
    rob_dispatch u_dispatch (
        .alu_broadcast (alu_broadcast),
        .rst           (rst),
        .dispatch      (dispatch),
        .flush         (flush),
        .alloc_we      (alloc_we),
        .alloc_tag     (alloc_tag),
        .alloc_entry   (alloc_entry)
    );

    // entry storage, writebacks land here
    rob_entry_table u_entry_table (
        .alu_broadcast (alu_broadcast),
        .rst           (rst),
        .alloc_we      (alloc_we),
        .alloc_tag     (alloc_tag),
        .alloc_entry   (alloc_entry),
        .alu_wb        (alu_wb),
        .lsb_wb        (lsb_wb),
        .head_tag      (head_tag),
        .retire        (retire),
        .flush         (flush),
        .head_entry    (head_entry)
    );

    // output side, head pointer and commit fsm
    rob_commit u_commit (
        .alu_broadcast (alu_broadcast),
        .rst           (rst),
        .head_entry    (head_entry),
        .store_done    (store_done),
        .head_tag      (head_tag),
        .retire        (retire),
        .flush         (flush),
        .reg_commit    (reg_commit),
        .store_req     (store_req),
        .credit_return (credit_return),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

endmodule

//--- rob_commit.sv
`timescale 1ns/1ps

module rob_commit import rob_pkg::*; (
    input  logic        alu_broadcast,
    input  logic        rst,
    input  rob_entry_t  head_entry,
    input  logic        store_done,
    output rob_tag_t    head_tag,
    output logic        retire,
    output logic        flush,
    output reg_commit_t reg_commit,
    output store_req_t  store_req,
    output logic        credit_return,
    output logic        redirect,
    output addr_t       redirect_pc
);

    commit_state_t state;

    logic  taken;
    logic  mispredict;
    addr_t fix_pc;

    // head may leave only when idle and not in the flush cycle
    assign retire = (state == st_idle) && head_entry.busy && head_entry.ready && !flush;

    // actual branch direction sits in value bit 0
    assign taken      = head_entry.value[0];
    assign mispredict = (head_entry.kind == kind_branch)
                        && (taken != head_entry.predicted_taken);

    // taken target from alu, else fall through
    assign fix_pc = taken ? head_entry.addr : head_entry.pc + addr_t'(4);

    always_ff @(posedge alu_broadcast) begin
        if (rst) begin
            state            <= st_idle;
            head_tag         <= '0;
            reg_commit.valid <= 1'b0;
            store_req.valid  <= 1'b0;
            credit_return    <= 1'b0;
            redirect         <= 1'b0;
            flush            <= 1'b0;
        end else begin
            // single cycle pulses by default
            reg_commit.valid <= 1'b0;
            credit_return    <= 1'b0;
            redirect         <= 1'b0;
            flush            <= 1'b0;

            // head pointer
            if (flush) begin
                head_tag <= '0;
            end else if (retire) begin
                head_tag <= head_tag + rob_tag_t'(1);
            end

            case (state)
                st_idle: begin
                    if (retire) begin
                        // one credit back per retired entry, whatever the kind
                        credit_return <= 1'b1;
                        case (head_entry.kind)
                            kind_store: begin
                                // store leaves the buffer now, lsb finishes it
                                store_req.valid <= 1'b1;
                                store_req.size  <= head_entry.size;
                                store_req.addr  <= head_entry.addr;
                                store_req.data  <= head_entry.value;
                                state           <= st_store_wait;
                            end
                            kind_branch: begin
                                if (mispredict) begin
                                    redirect    <= 1'b1;
                                    redirect_pc <= fix_pc;
                                    // younger entries go at the next edge
                                    flush       <= 1'b1;
                                end
                            end
                            default: begin
                                // alu and load ops write rd
                                reg_commit.valid <= 1'b1;
                                reg_commit.rd    <= head_entry.rd;
                                reg_commit.tag   <= head_tag;
                                reg_commit.value <= head_entry.value;
                            end
                        endcase
                    end
                end
                st_store_wait: begin
                    // hold store_req steady, commit stalls meanwhile
                    if (store_done) begin
                        store_req.valid <= 1'b0;
                        state           <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- rob_entry_table.sv
`timescale 1ns/1ps

module rob_entry_table import rob_pkg::*; (
    input  logic       alu_broadcast,
    input  logic       rst,
    input  logic       alloc_we,
    input  rob_tag_t   alloc_tag,
    input  rob_entry_t alloc_entry,
    input  wb_t        alu_wb,
    input  wb_t        lsb_wb,
    input  rob_tag_t   head_tag,
    input  logic       retire,
    input  logic       flush,
    output rob_entry_t head_entry
);

    rob_entry_t entries [rob_depth];

    // head read is combinational, commit decides in the same cycle
    assign head_entry = entries[head_tag];

    always_ff @(posedge alu_broadcast) begin
        if (rst) begin
            // only busy/ready matter after reset, payload is rewritten on alloc
            for (int i = 0; i < rob_depth; i++) begin
                entries[i].busy  <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            // head leaves, slot becomes free
            if (retire) begin
                entries[head_tag].busy  <= 1'b0;
                entries[head_tag].ready <= 1'b0;
            end

            // new entry at the tail
            // credits keep the tail off a busy head, so no clash with retire
            if (alloc_we) begin
                entries[alloc_tag] <= alloc_entry;
            end

            // alu result, also branch direction and target
            // ignore tags already freed by a flush
            if (alu_wb.valid && entries[alu_wb.tag].busy) begin
                entries[alu_wb.tag].value <= alu_wb.value;
                entries[alu_wb.tag].addr  <= alu_wb.addr;
                entries[alu_wb.tag].ready <= 1'b1;
            end

            // load data, or store data plus address in one go
            if (lsb_wb.valid && entries[lsb_wb.tag].busy) begin
                entries[lsb_wb.tag].value <= lsb_wb.value;
                if (entries[lsb_wb.tag].kind == kind_store) begin
                    entries[lsb_wb.tag].addr <= lsb_wb.addr;
                end
                entries[lsb_wb.tag].ready <= 1'b1;
            end

            // mispredict, drop everything younger than the branch
            // overrides the updates above
            if (flush) begin
                for (int i = 0; i < rob_depth; i++) begin
                    entries[i].busy  <= 1'b0;
                    entries[i].ready <= 1'b0;
                end
            end
        end
    end

endmodule

//--- rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch import rob_pkg::*; (
    input  logic          alu_broadcast,
    input  logic          rst,
    input  dispatch_req_t dispatch,
    input  logic          flush,
    output logic          alloc_we,
    output rob_tag_t      alloc_tag,
    output rob_entry_t    alloc_entry
);

    // next free slot, wraps with the 4 bit tag
    rob_tag_t    tail;
    op_kind_t    kind;
    store_size_t size;
    reg_idx_t    rd;

    // dispatcher holds a credit whenever valid is high, never refused
    assign alloc_we  = dispatch.valid;
    assign alloc_tag = tail;

    always_ff @(posedge alu_broadcast) begin
        if (rst || flush) begin
            tail <= '0;
        end else if (dispatch.valid) begin
            tail <= tail + rob_tag_t'(1);
        end
    end

    // classify the op from its major opcode
    always_comb begin
        kind = kind_alu;
        rd   = dispatch.rd;
        case (dispatch.opcode)
            opc_load: begin
                kind = kind_load;
            end
            opc_store: begin
                kind = kind_store;
                // stores and branches never touch the register file
                rd   = '0;
            end
            opc_branch: begin
                kind = kind_branch;
                rd   = '0;
            end
            default: begin
                kind = kind_alu;
            end
        endcase
        // width only matters for stores
        case (dispatch.funct3[1:0])
            2'b00:   size = size_byte;
            2'b01:   size = size_half;
            default: size = size_word;
        endcase
    end

    // fresh entry, busy and waiting for its writeback
    assign alloc_entry = '{
        busy:            1'b1,
        ready:           1'b0,
        kind:            kind,
        size:            size,
        rd:              rd,
        pc:              dispatch.pc,
        predicted_taken: dispatch.predicted_taken,
        value:           '0,
        addr:            '0
    };

endmodule

//--- rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 16;
    localparam int tag_w     = 4;
    localparam int xlen      = 32;
    localparam int reg_w     = 5;

    typedef logic [tag_w-1:0] rob_tag_t;
    typedef logic [xlen-1:0]  word_t;
    typedef logic [xlen-1:0]  addr_t;
    typedef logic [reg_w-1:0] reg_idx_t;
    typedef logic [1:0]       op_kind_t;
    typedef logic [1:0]       store_size_t;

    // op kinds kept per entry
    localparam op_kind_t kind_alu    = 2'd0;
    localparam op_kind_t kind_load   = 2'd1;
    localparam op_kind_t kind_store  = 2'd2;
    localparam op_kind_t kind_branch = 2'd3;

    // store width, same order as funct3[1:0] of sb/sh/sw
    localparam store_size_t size_byte = 2'd0;
    localparam store_size_t size_half = 2'd1;
    localparam store_size_t size_word = 2'd2;

    // rv32 major opcodes the dispatch decode looks at
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    typedef enum logic {
        st_idle,
        st_store_wait
    } commit_state_t;

    typedef struct packed {
        logic       valid;
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        addr_t      pc;
        logic       predicted_taken;
    } dispatch_req_t;

    typedef struct packed {
        logic        busy;
        logic        ready;
        op_kind_t    kind;
        store_size_t size;
        reg_idx_t    rd;
        addr_t       pc;
        logic        predicted_taken;
        // result, store data, or branch direction in bit 0
        word_t       value;
        // branch target or store address
        addr_t       addr;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        addr_t    addr;
    } wb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        rob_tag_t tag;
        word_t    value;
    } reg_commit_t;

    typedef struct packed {
        logic        valid;
        store_size_t size;
        addr_t       addr;
        word_t       data;
    } store_req_t;

endpackage
